// File: riscv_pkg.sv
package riscv_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int opcode_w   = 7;

    // major opcodes of the supported subset
    localparam logic [opcode_w-1:0] op_load   = 7'b0000011;
    localparam logic [opcode_w-1:0] op_store  = 7'b0100011;
    localparam logic [opcode_w-1:0] op_reg    = 7'b0110011;
    localparam logic [opcode_w-1:0] op_imm    = 7'b0010011;
    localparam logic [opcode_w-1:0] op_branch = 7'b1100011;
    localparam logic [opcode_w-1:0] op_jal    = 7'b1101111;
    localparam logic [opcode_w-1:0] op_jalr   = 7'b1100111;
    localparam logic [opcode_w-1:0] op_lui    = 7'b0110111;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [opcode_w-1:0]   opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]           imm_11_0;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [opcode_w-1:0]   opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]            imm_11_5;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_4_0;
        logic [opcode_w-1:0]   opcode;
    } s_fmt_t;

    typedef struct packed {
        logic                  imm_12;
        logic [5:0]            imm_10_5;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [3:0]            imm_4_1;
        logic                  imm_11;
        logic [opcode_w-1:0]   opcode;
    } b_fmt_t;

    // u and j share the layout, j scrambles the upper 20 bits
    typedef struct packed {
        logic [19:0]           imm_31_12;
        logic [reg_addr_w-1:0] rd;
        logic [opcode_w-1:0]   opcode;
    } uj_fmt_t;

    typedef union packed {
        r_fmt_t  r;
        i_fmt_t  i;
        s_fmt_t  s;
        b_fmt_t  b;
        uj_fmt_t uj;
    } instr_u;

    typedef enum logic [2:0] {
        imm_i = 3'b000,
        imm_s = 3'b001,
        imm_b = 3'b010,
        imm_j = 3'b011,
        imm_u = 3'b100
    } imm_src_e;

    typedef enum logic [2:0] {
        alu_add    = 3'b000,
        alu_sub    = 3'b001,
        alu_and    = 3'b010,
        alu_or     = 3'b011,
        alu_xor    = 3'b100,
        alu_slt    = 3'b101,
        alu_sll    = 3'b110,
        alu_pass_b = 3'b111
    } alu_op_e;

    typedef enum logic [1:0] {
        size_none = 2'b00,
        size_byte = 2'b01,
        size_half = 2'b10,
        size_word = 2'b11
    } mem_size_e;

    typedef enum logic [1:0] {
        res_alu = 2'b00,
        res_mem = 2'b01,
        res_pc4 = 2'b10
    } result_src_e;

    typedef enum logic [1:0] {
        pc_plus4  = 2'b00,
        pc_branch = 2'b01,
        pc_jalr   = 2'b10
    } pc_src_e;

endpackage

// File: alu.sv
`timescale 1ns/1ps

module alu (
    input  logic [riscv_pkg::xlen-1:0] a_i,
    input  logic [riscv_pkg::xlen-1:0] b_i,
    input  riscv_pkg::alu_op_e         op_i,
    output logic [riscv_pkg::xlen-1:0] result_o,
    output logic                       zero_o
);

    import riscv_pkg::*;

    logic lt_signed;

    assign lt_signed = $signed(a_i) < $signed(b_i);

    always_comb
    begin
        case (op_i)
            alu_add:    result_o = a_i + b_i;
            alu_sub:    result_o = a_i - b_i;
            alu_and:    result_o = a_i & b_i;
            alu_or:     result_o = a_i | b_i;
            alu_xor:    result_o = a_i ^ b_i;
            alu_slt:    result_o = {{(xlen-1){1'b0}}, lt_signed};
            alu_sll:    result_o = a_i << b_i[4:0];     // shamt is 5 bits
            alu_pass_b: result_o = b_i;                 // lui
            default:    result_o = a_i + b_i;
        endcase
    end

    assign zero_o = (result_o == '0);

endmodule

// File: reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  logic [riscv_pkg::reg_addr_w-1:0] rs1_i,
    input  logic [riscv_pkg::reg_addr_w-1:0] rs2_i,
    input  logic [riscv_pkg::reg_addr_w-1:0] rd_i,
    input  logic                             we_i,
    input  logic [riscv_pkg::xlen-1:0]       wdata_i,
    output logic [riscv_pkg::xlen-1:0]       rdata1_o,
    output logic [riscv_pkg::xlen-1:0]       rdata2_o
);

    logic [riscv_pkg::xlen-1:0] regs [32];

    always_ff @(posedge clk_i)
    begin
        if (!rst_n_i)
        begin
            for (int k = 0; k < 32; k++)
            begin
                regs[k] <= '0;
            end
        end
        else if (we_i && (rd_i != '0))                  // x0 stays zero
        begin
            regs[rd_i] <= wdata_i;
        end
    end

    // asynchronous read ports
    assign rdata1_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign rdata2_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

// File: imm_extend.sv
`timescale 1ns/1ps

module imm_extend (
    input  riscv_pkg::instr_u          instr_i,
    input  riscv_pkg::imm_src_e        imm_src_i,
    output logic [riscv_pkg::xlen-1:0] imm_o
);

    import riscv_pkg::*;

    logic [19:0] upper;     // shared u/j immediate bits

    assign upper = instr_i.uj.imm_31_12;

    always_comb
    begin
        case (imm_src_i)
            imm_i:
                imm_o = {{20{instr_i.i.imm_11_0[11]}}, instr_i.i.imm_11_0};
            imm_s:
                imm_o = {{20{instr_i.s.imm_11_5[6]}}, instr_i.s.imm_11_5,
                         instr_i.s.imm_4_0};
            imm_b:
                imm_o = {{19{instr_i.b.imm_12}}, instr_i.b.imm_12, instr_i.b.imm_11,
                         instr_i.b.imm_10_5, instr_i.b.imm_4_1, 1'b0};
            imm_j:
                // imm[20|10:1|11|19:12] sits in instr[31:12]
                imm_o = {{11{upper[19]}}, upper[19], upper[7:0], upper[8],
                         upper[18:9], 1'b0};
            imm_u:
                imm_o = {upper, 12'b0};
            default:
                imm_o = {{20{instr_i.i.imm_11_0[11]}}, instr_i.i.imm_11_0};
        endcase
    end

endmodule

// File: load_store_unit.sv
`timescale 1ns/1ps

module load_store_unit (
    input  logic                       mem_write_i,
    input  riscv_pkg::mem_size_e       mem_size_i,
    input  logic                       load_unsigned_i,
    input  logic [1:0]                 addr_lsb_i,
    input  logic [riscv_pkg::xlen-1:0] store_data_i,
    input  logic [riscv_pkg::xlen-1:0] rdata_i,
    output logic [3:0]                 be_o,
    output logic [riscv_pkg::xlen-1:0] wdata_o,
    output logic [riscv_pkg::xlen-1:0] load_data_o
);

    import riscv_pkg::*;

    logic [3:0]  lanes;
    logic [7:0]  lane_byte;
    logic [15:0] lane_half;

    // store side
    always_comb
    begin
        case (mem_size_i)
            size_byte:
            begin
                wdata_o = {4{store_data_i[7:0]}};       // replicate into all lanes
                lanes   = 4'b0001 << addr_lsb_i;
            end
            size_half:
            begin
                wdata_o = {2{store_data_i[15:0]}};
                lanes   = addr_lsb_i[1] ? 4'b1100 : 4'b0011;
            end
            size_word:
            begin
                wdata_o = store_data_i;
                lanes   = 4'b1111;
            end
            default:
            begin
                wdata_o = store_data_i;
                lanes   = 4'b0000;
            end
        endcase
    end

    assign be_o = mem_write_i ? lanes : 4'b0000;

    // load side
    always_comb
    begin
        case (addr_lsb_i)
            2'd0:    lane_byte = rdata_i[7:0];
            2'd1:    lane_byte = rdata_i[15:8];
            2'd2:    lane_byte = rdata_i[23:16];
            default: lane_byte = rdata_i[31:24];
        endcase
    end

    assign lane_half = addr_lsb_i[1] ? rdata_i[31:16] : rdata_i[15:0];

    always_comb
    begin
        case (mem_size_i)
            size_byte: load_data_o = {{24{lane_byte[7] & ~load_unsigned_i}}, lane_byte};
            size_half: load_data_o = {{16{lane_half[15] & ~load_unsigned_i}}, lane_half};
            default:   load_data_o = rdata_i;           // lw
        endcase
    end

endmodule

// File: pc_unit.sv
`timescale 1ns/1ps

module pc_unit #(
    parameter logic [riscv_pkg::xlen-1:0] reset_pc = '0
) (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  riscv_pkg::pc_src_e         pc_src_i,
    input  logic [riscv_pkg::xlen-1:0] imm_i,
    input  logic [riscv_pkg::xlen-1:0] alu_result_i,
    output logic [riscv_pkg::xlen-1:0] pc_o,
    output logic [riscv_pkg::xlen-1:0] pc_plus4_o
);

    import riscv_pkg::*;

    logic [xlen-1:0] pc_next;

    assign pc_plus4_o = pc_o + xlen'(4);

    always_comb
    begin
        case (pc_src_i)
            pc_branch: pc_next = pc_o + imm_i;          // branch and jal target
            pc_jalr:   pc_next = alu_result_i & ~xlen'(1);
            default:   pc_next = pc_plus4_o;
        endcase
    end

    always_ff @(posedge clk_i)
    begin
        if (!rst_n_i)
        begin
            pc_o <= reset_pc;
        end
        else
        begin
            pc_o <= pc_next;
        end
    end

endmodule

// File: control_unit.sv
`timescale 1ns/1ps

module control_unit (
    input  riscv_pkg::instr_u      instr_i,
    input  logic                   zero_i,
    output logic                   reg_write_o,
    output logic                   mem_write_o,
    output logic                   load_unsigned_o,
    output logic                   alu_src_o,
    output riscv_pkg::mem_size_e   mem_size_o,
    output riscv_pkg::result_src_e result_src_o,
    output riscv_pkg::alu_op_e     alu_op_o,
    output riscv_pkg::imm_src_e    imm_src_o,
    output riscv_pkg::pc_src_e     pc_src_o
);

    import riscv_pkg::*;

    pc_src_e pc_sel;       // next pc for non-branch opcodes
    logic    is_branch;
    logic    branch_taken;

    function automatic mem_size_e size_of(input logic [1:0] f3_lo);
        case (f3_lo)
            2'b00:   return size_byte;
            2'b01:   return size_half;
            default: return size_word;
        endcase
    endfunction

    always_comb
    begin
        // addi-style defaults, also the fallback for unknown opcodes
        reg_write_o     = 1'b1;
        mem_write_o     = 1'b0;
        load_unsigned_o = 1'b0;
        alu_src_o       = 1'b1;
        mem_size_o      = size_none;
        result_src_o    = res_alu;
        alu_op_o        = alu_add;
        imm_src_o       = imm_i;
        pc_sel          = pc_plus4;
        is_branch       = 1'b0;

        case (instr_i.r.opcode)
            op_load:
            begin
                result_src_o    = res_mem;
                mem_size_o      = size_of(instr_i.r.funct3[1:0]);
                load_unsigned_o = instr_i.r.funct3[2];  // lbu, lhu
            end
            op_store:
            begin
                reg_write_o = 1'b0;
                mem_write_o = 1'b1;
                imm_src_o   = imm_s;
                mem_size_o  = size_of(instr_i.r.funct3[1:0]);
            end
            op_reg:
            begin
                alu_src_o = 1'b0;
                case (instr_i.r.funct3)
                    3'b000:  alu_op_o = instr_i.r.funct7[5] ? alu_sub : alu_add;
                    3'b010:  alu_op_o = alu_slt;
                    3'b110:  alu_op_o = alu_or;
                    3'b111:  alu_op_o = alu_and;
                    default: alu_op_o = alu_add;
                endcase
            end
            op_imm:
            begin
                if (instr_i.r.funct3 == 3'b001)
                begin
                    alu_op_o = alu_sll;                 // slli
                end
            end
            op_branch:
            begin
                reg_write_o = 1'b0;
                alu_src_o   = 1'b0;
                alu_op_o    = alu_sub;                  // compare via zero flag
                imm_src_o   = imm_b;
                is_branch   = 1'b1;
            end
            op_jal:
            begin
                imm_src_o    = imm_j;
                result_src_o = res_pc4;                 // link
                pc_sel       = pc_branch;
            end
            op_jalr:
            begin
                reg_write_o = 1'b0;                     // no link write here
                pc_sel      = pc_jalr;
            end
            op_lui:
            begin
                imm_src_o = imm_u;
                alu_op_o  = alu_pass_b;
            end
            default:
            begin
                reg_write_o = 1'b1;
            end
        endcase
    end

    // beq takes on zero, bne on nonzero
    assign branch_taken = zero_i ^ instr_i.r.funct3[0];

    assign pc_src_o = is_branch ? (branch_taken ? pc_branch : pc_plus4) : pc_sel;

endmodule

// File: riscv_core.sv
`timescale 1ns/1ps

module riscv_core #(
    parameter logic [riscv_pkg::xlen-1:0] reset_pc = '0
) (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    output logic [riscv_pkg::xlen-1:0] imem_addr_o,
    input  logic [riscv_pkg::xlen-1:0] imem_data_i,
    output logic [riscv_pkg::xlen-1:0] dmem_addr_o,
    output logic                       dmem_we_o,
    output logic [3:0]                 dmem_be_o,
    output logic [riscv_pkg::xlen-1:0] dmem_wdata_o,
    input  logic [riscv_pkg::xlen-1:0] dmem_rdata_i
);

    import riscv_pkg::*;

    instr_u      instr;
    logic        reg_write;
    logic        mem_write;
    logic        load_unsigned;
    logic        alu_src;
    mem_size_e   mem_size;
    result_src_e result_src;
    alu_op_e     alu_op;
    imm_src_e    imm_src;
    pc_src_e     pc_src;
    logic        zero;

    logic [xlen-1:0] rdata1;
    logic [xlen-1:0] rdata2;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] alu_b;
    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] load_data;
    logic [xlen-1:0] pc_plus4;
    logic [xlen-1:0] result;

    assign instr = imem_data_i;

    control_unit i_control_unit (
        .instr_i         (instr),
        .zero_i          (zero),
        .reg_write_o     (reg_write),
        .mem_write_o     (mem_write),
        .load_unsigned_o (load_unsigned),
        .alu_src_o       (alu_src),
        .mem_size_o      (mem_size),
        .result_src_o    (result_src),
        .alu_op_o        (alu_op),
        .imm_src_o       (imm_src),
        .pc_src_o        (pc_src)
    );

    reg_file i_reg_file (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .rs1_i    (instr.r.rs1),
        .rs2_i    (instr.r.rs2),
        .rd_i     (instr.r.rd),
        .we_i     (reg_write),
        .wdata_i  (result),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2)
    );

    imm_extend i_imm_extend (
        .instr_i   (instr),
        .imm_src_i (imm_src),
        .imm_o     (imm)
    );

    assign alu_b = alu_src ? imm : rdata2;  // operand b mux

    alu i_alu (
        .a_i      (rdata1),
        .b_i      (alu_b),
        .op_i     (alu_op),
        .result_o (alu_result),
        .zero_o   (zero)
    );

    load_store_unit i_load_store_unit (
        .mem_write_i     (mem_write),
        .mem_size_i      (mem_size),
        .load_unsigned_i (load_unsigned),
        .addr_lsb_i      (alu_result[1:0]),
        .store_data_i    (rdata2),
        .rdata_i         (dmem_rdata_i),
        .be_o            (dmem_be_o),
        .wdata_o         (dmem_wdata_o),
        .load_data_o     (load_data)
    );

    pc_unit #(
        .reset_pc (reset_pc)
    ) i_pc_unit (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .pc_src_i     (pc_src),
        .imm_i        (imm),
        .alu_result_i (alu_result),
        .pc_o         (imem_addr_o),
        .pc_plus4_o   (pc_plus4)
    );

    // write-back mux
    always_comb
    begin
        case (result_src)
            res_mem: result = load_data;
            res_pc4: result = pc_plus4;             // jal link
            default: result = alu_result;
        endcase
    end

    assign dmem_addr_o = alu_result;
    assign dmem_we_o   = mem_write & rst_n_i;       // no stores while in reset

endmodule

// File: riscv_core_assert.sv
`timescale 1ns/1ps

module riscv_core_assert (
    input logic                       clk_i,
    input logic                       rst_n_i,
    input logic [riscv_pkg::xlen-1:0] imem_addr_i,
    input logic                       dmem_we_i,
    input logic [3:0]                 dmem_be_i,
    input riscv_pkg::pc_src_e         pc_src_i
);

    import riscv_pkg::*;

    // the pc is only defined after the first reset edge
    fetch_aligned: assert property (@(posedge clk_i) rst_n_i |-> imem_addr_i[1:0] == 2'b00)
        else $error("fetch address 0x%08h is not word aligned", imem_addr_i);

    no_store_in_reset: assert property (@(posedge clk_i) !rst_n_i |-> !dmem_we_i)
        else $error("store strobe high while reset is active");

    store_has_lanes: assert property (@(posedge clk_i) dmem_we_i |-> dmem_be_i != 4'b0000)
        else $error("store strobe high with no byte lane enabled");

    pc_step: assert property (@(posedge clk_i)
        (rst_n_i && pc_src_i == pc_plus4) |=> imem_addr_i == $past(imem_addr_i) + 32'd4)
        else $error("pc did not advance by 4 after a sequential instruction");

endmodule

// File: tb_riscv_core.sv
`timescale 1ns/1ps

module tb_riscv_core;

    localparam logic [31:0] reset_pc     = 32'h0000_0400;
    localparam logic [31:0] reset_instr  = 32'h0000_2023;  // sw x0, 0(x0), held during reset
    localparam int          clk_period   = 4;
    localparam int          reset_cycles = 16;
    localparam int          max_rows     = 64;
    localparam logic [6:0]  opc_imm      = 7'b0010011;
    localparam logic [6:0]  opc_load     = 7'b0000011;
    localparam logic [6:0]  opc_jalr     = 7'b1100111;

    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] next_pc;   // expected imem_addr_o after this row
        logic        we;
        logic [31:0] addr;
        logic [3:0]  be;
        logic [31:0] wdata;
        logic [2:0]  test;
    } row_t;

    logic        clk = 1'b0;
    logic        rst_n;
    logic [31:0] imem_addr;
    logic [31:0] imem_data;
    logic [31:0] dmem_addr;
    logic        dmem_we;
    logic [3:0]  dmem_be;
    logic [31:0] dmem_wdata;
    logic [31:0] dmem_rdata;

    row_t        tbl [max_rows];
    int          n_rows = 0;
    logic [2:0]  cur_test;
    logic [31:0] pc_b;          // pc of the row being built
    logic [31:0] xr [32];       // expected register contents
    logic [31:0] mem_init [16];
    logic [31:0] mem_model [16];
    logic [31:0] dmem [16];
    logic [31:0] lfsr_state;
    logic        built = 1'b0;
    int          errors = 0;
    int          executed = 0;
    int          test_err [8];

    always #(clk_period / 2) clk = ~clk;

    riscv_core #(
        .reset_pc (reset_pc)
    ) i_riscv_core (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .imem_addr_o  (imem_addr),
        .imem_data_i  (imem_data),
        .dmem_addr_o  (dmem_addr),
        .dmem_we_o    (dmem_we),
        .dmem_be_o    (dmem_be),
        .dmem_wdata_o (dmem_wdata),
        .dmem_rdata_i (dmem_rdata)
    );

    bind riscv_core riscv_core_assert i_riscv_core_assert (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .imem_addr_i (imem_addr_o),
        .dmem_we_i   (dmem_we_o),
        .dmem_be_i   (dmem_be_o),
        .pc_src_i    (pc_src)
    );

    // data memory, 16 words, loaded during reset
    assign dmem_rdata = dmem[dmem_addr[5:2]];

    always @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int k = 0; k < 16; k++)
            begin
                dmem[k] <= mem_init[k];
            end
        end
        else if (dmem_we)
        begin
            for (int b = 0; b < 4; b++)
            begin
                if (dmem_be[b])
                begin
                    dmem[dmem_addr[5:2]][8*b +: 8] <= dmem_wdata[8*b +: 8];
                end
            end
        end
    end

    // galois lfsr, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++)
        begin
            v = {v[30:0], lfsr_state[0]};
            if (lfsr_state[0])
            begin
                lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
            end
            else
            begin
                lfsr_state = lfsr_state >> 1;
            end
        end
        return v;
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] b_word(input logic [12:0] off, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] j_word(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic string test_name(input logic [2:0] t);
        case (t)
            3'd1:    return "reset";
            3'd2:    return "alu and immediates";
            3'd3:    return "stores by size";
            3'd4:    return "loads and extension";
            3'd5:    return "branches";
            3'd6:    return "jumps";
            default: return "unknown";
        endcase
    endfunction

    task automatic add_row(input logic [31:0] instr, input logic [31:0] next_pc,
                           input logic we, input logic [31:0] addr, input logic [3:0] be,
                           input logic [31:0] wdata);
        tbl[n_rows].instr   = instr;
        tbl[n_rows].next_pc = next_pc;
        tbl[n_rows].we      = we;
        tbl[n_rows].addr    = addr;
        tbl[n_rows].be      = be;
        tbl[n_rows].wdata   = wdata;
        tbl[n_rows].test    = cur_test;
        n_rows++;
        pc_b = pc_b + 32'd4;
    endtask

    task automatic put_alu(input logic [31:0] instr, input logic [4:0] rd,
                           input logic [31:0] value);
        add_row(instr, pc_b + 32'd4, 1'b0, 32'h0, 4'h0, 32'h0);
        if (rd != 5'd0)
        begin
            xr[rd] = value;
        end
    endtask

    // never executed, lands in the shadow of a taken branch or jump
    task automatic put_filler();
        add_row(i_word(12'h7ff, 5'd0, 3'b000, 5'd31, opc_imm), pc_b + 32'd4,
                1'b0, 32'h0, 4'h0, 32'h0);
    endtask

    task automatic put_store(input logic [2:0] f3, input logic [4:0] rs2,
                             input logic [11:0] off);
        logic [31:0] addr;
        logic [31:0] wd;
        logic [3:0]  be;
        int          nbytes;
        addr = xr[1] + sext12(off);
        case (f3)
            3'b000:
            begin
                wd     = {4{xr[rs2][7:0]}};
                nbytes = 1;
            end
            3'b001:
            begin
                wd     = {2{xr[rs2][15:0]}};
                nbytes = 2;
            end
            default:
            begin
                wd     = xr[rs2];
                nbytes = 4;
            end
        endcase
        for (int b = 0; b < 4; b++)
        begin
            // lanes from the byte offset up to the access size
            be[b] = (b >= int'(addr[1:0])) && (b < int'(addr[1:0]) + nbytes);
            if (be[b])
            begin
                mem_model[addr[5:2]][8*b +: 8] = wd[8*b +: 8];
            end
        end
        add_row({off[11:5], rs2, 5'd1, f3, off[4:0], 7'b0100011}, pc_b + 32'd4,
                1'b1, addr, be, wd);
    endtask

    task automatic put_load(input logic [2:0] f3, input logic [4:0] rd, input logic [11:0] off);
        logic [31:0] addr;
        logic [31:0] word;
        logic [7:0]  bt;
        logic [15:0] hw;
        logic [31:0] val;
        addr = xr[1] + sext12(off);
        word = mem_model[addr[5:2]];
        bt   = word[8*addr[1:0] +: 8];
        hw   = word[16*addr[1] +: 16];
        case (f3)
            3'b000:  val = {{24{bt[7]}}, bt};   // lb
            3'b100:  val = {24'h0, bt};         // lbu
            3'b001:  val = {{16{hw[15]}}, hw};  // lh
            3'b101:  val = {16'h0, hw};         // lhu
            default: val = word;
        endcase
        put_alu(i_word(off, 5'd1, f3, rd, opc_load), rd, val);
    endtask

    task automatic put_branch(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2);
        logic taken;
        if (f3 == 3'b000)
        begin
            taken = (xr[rs1] == xr[rs2]);       // beq
        end
        else
        begin
            taken = (xr[rs1] != xr[rs2]);       // bne
        end
        add_row(b_word(13'd8, rs2, rs1, f3), taken ? pc_b + 32'd8 : pc_b + 32'd4,
                1'b0, 32'h0, 4'h0, 32'h0);
        if (taken)
        begin
            put_filler();
        end
    endtask

    task automatic build_program();
        logic [31:0] rnd_a;
        logic [31:0] rnd_b;
        logic [31:0] rnd_s;
        logic [31:0] rnd_u;
        logic [31:0] link;
        logic [31:0] offv;
        rnd_a = rand_bits(12);
        rnd_b = rand_bits(12);
        if (rnd_b == rnd_a)
        begin
            rnd_b = rnd_a ^ 32'h1;              // keep x2 and x3 apart
        end
        rnd_s = rand_bits(5);
        rnd_u = rand_bits(20);
        pc_b  = reset_pc;

        cur_test = 3'd2;
        put_alu(i_word(12'h100, 5'd0, 3'b000, 5'd1, opc_imm), 5'd1, 32'h100);  // data base
        put_alu(i_word(rnd_a[11:0], 5'd0, 3'b000, 5'd2, opc_imm), 5'd2, sext12(rnd_a[11:0]));
        put_store(3'b010, 5'd2, 12'h000);
        put_alu(i_word(rnd_b[11:0], 5'd0, 3'b000, 5'd3, opc_imm), 5'd3, sext12(rnd_b[11:0]));
        put_store(3'b010, 5'd3, 12'h004);
        put_alu(r_word(7'h00, 5'd3, 5'd2, 3'b000, 5'd4), 5'd4, xr[2] + xr[3]);
        put_store(3'b010, 5'd4, 12'h008);
        put_alu(r_word(7'h20, 5'd3, 5'd2, 3'b000, 5'd5), 5'd5, xr[2] - xr[3]);
        put_store(3'b010, 5'd5, 12'h00c);
        put_alu(r_word(7'h00, 5'd3, 5'd2, 3'b111, 5'd6), 5'd6, xr[2] & xr[3]);
        put_store(3'b010, 5'd6, 12'h010);
        put_alu(r_word(7'h00, 5'd3, 5'd2, 3'b110, 5'd7), 5'd7, xr[2] | xr[3]);
        put_store(3'b010, 5'd7, 12'h014);
        put_alu(r_word(7'h00, 5'd3, 5'd2, 3'b010, 5'd8), 5'd8,
                ($signed(xr[2]) < $signed(xr[3])) ? 32'd1 : 32'd0);
        put_store(3'b010, 5'd8, 12'h018);
        put_alu(i_word({7'h00, rnd_s[4:0]}, 5'd2, 3'b001, 5'd9, opc_imm), 5'd9,
                xr[2] << rnd_s[4:0]);
        put_store(3'b010, 5'd9, 12'h01c);
        put_alu({rnd_u[19:0], 5'd10, 7'b0110111}, 5'd10, {rnd_u[19:0], 12'h000});  // lui
        put_store(3'b010, 5'd10, 12'h020);

        cur_test = 3'd3;
        for (int k = 0; k < 4; k++)
        begin
            put_store(3'b000, 5'd2, 12'h024 + 12'(k));
        end
        put_store(3'b001, 5'd3, 12'h028);
        put_store(3'b001, 5'd3, 12'h02a);

        cur_test = 3'd4;
        put_load(3'b000, 5'd11, 12'h031);
        put_store(3'b010, 5'd11, 12'h02c);
        put_load(3'b100, 5'd11, 12'h033);
        put_store(3'b010, 5'd11, 12'h02c);
        put_load(3'b001, 5'd11, 12'h036);
        put_store(3'b010, 5'd11, 12'h02c);
        put_load(3'b101, 5'd11, 12'h03a);
        put_store(3'b010, 5'd11, 12'h02c);
        put_load(3'b010, 5'd11, 12'h03c);
        put_store(3'b010, 5'd11, 12'h02c);

        cur_test = 3'd5;
        put_branch(3'b000, 5'd2, 5'd2);         // beq taken
        put_branch(3'b000, 5'd2, 5'd3);         // beq not taken
        put_branch(3'b001, 5'd2, 5'd3);         // bne taken
        put_branch(3'b001, 5'd2, 5'd2);         // bne not taken

        cur_test = 3'd6;
        link = pc_b + 32'd4;
        add_row(j_word(21'd8, 5'd12), pc_b + 32'd8, 1'b0, 32'h0, 4'h0, 32'h0);
        xr[12] = link;
        put_filler();
        put_store(3'b010, 5'd12, 12'h02c);
        put_alu(i_word(12'h055, 5'd0, 3'b000, 5'd13, opc_imm), 5'd13, 32'h55);
        offv = pc_b + 32'd9 - xr[12];           // odd offset, bit 0 gets cleared
        add_row(i_word(offv[11:0], 5'd12, 3'b000, 5'd13, opc_jalr),
                (xr[12] + sext12(offv[11:0])) & ~32'h1, 1'b0, 32'h0, 4'h0, 32'h0);
        put_filler();
        put_store(3'b010, 5'd13, 12'h02c);      // x13 keeps its old value
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp, input logic [2:0] t);
        $display("** Error at %0t: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
        errors++;
        test_err[t]++;
    endtask

    task automatic report_test(input logic [2:0] t);
        $display("test %0d (%s) done, %0d errors", t, test_name(t), test_err[t]);
    endtask

    task automatic check_row(input int k);
        logic [31:0] pc_exp;
        logic [2:0]  t;
        pc_exp = reset_pc + 32'(4 * k);
        t      = tbl[k].test;
        if (imem_addr !== pc_exp)
        begin
            report_mismatch("imem_addr_o", imem_addr, pc_exp, t);
        end
        if (dmem_we !== tbl[k].we)
        begin
            report_mismatch("dmem_we_o", {31'h0, dmem_we}, {31'h0, tbl[k].we}, t);
        end
        if (dmem_be !== tbl[k].be)
        begin
            report_mismatch("dmem_be_o", {28'h0, dmem_be}, {28'h0, tbl[k].be}, t);
        end
        if (tbl[k].we && dmem_addr !== tbl[k].addr)
        begin
            report_mismatch("dmem_addr_o", dmem_addr, tbl[k].addr, t);
        end
        if (tbl[k].we && dmem_wdata !== tbl[k].wdata)
        begin
            report_mismatch("dmem_wdata_o", dmem_wdata, tbl[k].wdata, t);
        end
    endtask

    initial
    begin
        wait (built);
        #((reset_cycles + n_rows + 16) * clk_period);
        $display("watchdog expired before the instruction table was finished");
        $display("Test failed");
        $finish;
    end

    initial
    begin
        int idx;
        int nxt;
        rst_n      <= 1'b0;
        lfsr_state  = 32'hf3a4_94bb;
        for (int k = 0; k < 8; k++)
        begin
            test_err[k] = 0;
        end
        for (int k = 0; k < 32; k++)
        begin
            xr[k] = 32'h0;
        end
        for (int k = 0; k < 16; k++)
        begin
            mem_init[k]  = rand_bits(32);
            mem_model[k] = mem_init[k];
        end
        build_program();
        imem_data <= reset_instr;               // store decoded while reset holds the strobe
        built = 1'b1;

        repeat (reset_cycles)
        begin
            @(negedge clk);
            if (imem_addr !== reset_pc)
            begin
                report_mismatch("imem_addr_o", imem_addr, reset_pc, 3'd1);
            end
            if (dmem_we !== 1'b0)
            begin
                report_mismatch("dmem_we_o", {31'h0, dmem_we}, 32'h0, 3'd1);
            end
        end
        @(posedge clk);
        rst_n     <= 1'b1;
        imem_data <= tbl[0].instr;
        report_test(3'd1);

        idx = 0;
        while (idx < n_rows)
        begin
            @(negedge clk);                     // outputs settled mid-cycle
            check_row(idx);
            executed++;
            nxt = int'((tbl[idx].next_pc - reset_pc) >> 2);
            @(posedge clk);
            if (nxt >= n_rows || tbl[nxt].test != tbl[idx].test)
            begin
                report_test(tbl[idx].test);
            end
            imem_data <= (nxt < n_rows) ? tbl[nxt].instr : 32'h0000_0013;
            idx = nxt;
        end

        $display("%0d instructions executed, %0d errors", executed, errors);
        if (errors == 0)
        begin
            $display("Test completed successfully");
        end
        else
        begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: riscv_core.f
riscv_pkg.sv
alu.sv
reg_file.sv
imm_extend.sv
load_store_unit.sv
pc_unit.sv
control_unit.sv
riscv_core.sv
riscv_core_assert.sv
tb_riscv_core.sv

// File: Makefile
TOP = tb_riscv_core

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f riscv_core.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f riscv_core.f
	./obj_dir/V$(TOP) > sim.log 2>&1 || (cat sim.log; exit 1)
	cat sim.log
	if grep -q "Test failed" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
